//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // datapath width and register count for rv32e
    localparam int xlen    = 32;
    localparam int num_gpr = 16;

    // rv32i base opcodes, bits 6:0
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_op     = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    // r, i and s formats share this field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } inst_rsi_t;

    // u and j formats, upper 20 bits taken as one field
    typedef struct packed {
        logic [19:0] imm_hi;
        logic [4:0]  rd;
        opcode_e     opcode;
    } inst_uj_t;

    // same instruction word, two decodings
    typedef union packed {
        inst_rsi_t rsi;
        inst_uj_t  uj;
    } inst_u;

    // which immediate layout to extract
    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_type_e;

    // rv32e only has x0..x15
    typedef logic [3:0] reg_idx_t;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    // alu function seen by execute
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // operand source, register file or one of the later stages
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_exe,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    // control transfer kind
    typedef enum logic [2:0] {
        jump_none,
        jump_jal,
        jump_jalr,
        jump_branch
    } jump_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src_a;  // 1: pc instead of rs1
        logic       alu_src_b;  // 1: imm instead of rs2
        logic       gpr_write;
        wb_sel_e    wb_sel;
        jump_e      jump;
        logic       mem_read;
        logic       mem_write;
        logic [2:0] mem_size;   // funct3 of load/store
        logic       is_break;
        logic       illegal;
    } ctrl_t;

    // fetch side payload
    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0] inst;
        logic [rv_isa_pkg::xlen-1:0] pc;
    } id_in_t;

    // writeback port into the register file
    typedef struct packed {
        logic                        en;
        rv_isa_pkg::reg_idx_t        addr;
        logic [rv_isa_pkg::xlen-1:0] data;
    } gpr_wr_t;

    // forwarded results from later stages
    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0] exe;
        logic [rv_isa_pkg::xlen-1:0] mem;
        logic [rv_isa_pkg::xlen-1:0] wb;
    } fwd_data_t;

    // decode to execute payload
    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0] pc;
        logic [rv_isa_pkg::xlen-1:0] rs1_data;
        logic [rv_isa_pkg::xlen-1:0] rs2_data;
        logic [rv_isa_pkg::xlen-1:0] imm;
        rv_isa_pkg::reg_idx_t        rd;
        ctrl_t                       ctrl;
    } id_ex_t;

endpackage

//--- logic/gpr_file.sv
`timescale 1ns/1ps

module gpr_file
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clk,
    input  gpr_wr_t         wr,
    input  reg_idx_t        rs1_idx,
    input  reg_idx_t        rs2_idx,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    // storage, no reset on contents
    logic [xlen-1:0] regs [num_gpr];

    // writes to x0 dropped
    always_ff @(posedge clk) begin
        if (wr.en && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // async read, x0 forced to zero
    // no write-through here, wb forward covers it
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
    import rv_isa_pkg::*;
(
    input  inst_u           inst,
    input  imm_type_e       imm_type,
    output logic [xlen-1:0] imm
);

    // short names for the two views
    logic [6:0]  f7;
    logic [4:0]  lo5;
    logic [4:0]  rs2;
    logic [19:0] hi;

    assign f7  = inst.rsi.funct7;
    assign lo5 = inst.rsi.rd;
    assign rs2 = inst.rsi.rs2;
    assign hi  = inst.uj.imm_hi;

    always_comb begin
        case (imm_type)
            // inst[31:20]
            imm_i: imm = {{20{f7[6]}}, f7, rs2};
            // inst[31:25] and inst[11:7]
            imm_s: imm = {{20{f7[6]}}, f7, lo5};
            // bit 11 sits in inst[7], lsb always zero
            imm_b: imm = {{19{f7[6]}}, f7[6], lo5[0], f7[5:0], lo5[4:1], 1'b0};
            // upper 20 bits, low 12 cleared
            imm_u: imm = {hi, 12'b0};
            // scrambled jal layout
            imm_j: imm = {{12{hi[19]}}, hi[7:0], hi[8], hi[18:9], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- logic/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  inst_u     inst,
    output ctrl_t     ctrl,
    output imm_type_e imm_type,
    output logic      rs1_ren,
    output logic      rs2_ren
);

    // alu op from funct3, alt is funct7 bit 5
    // sub only exists in the register form
    function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic alt,
                                       input logic is_reg);
        case (f3)
            3'b000:  alu_fn = (is_reg && alt) ? alu_sub : alu_add;
            3'b001:  alu_fn = alu_sll;
            3'b010:  alu_fn = alu_slt;
            3'b011:  alu_fn = alu_sltu;
            3'b100:  alu_fn = alu_xor;
            3'b101:  alu_fn = alt ? alu_sra : alu_srl;
            3'b110:  alu_fn = alu_or;
            default: alu_fn = alu_and;
        endcase
    endfunction

    logic [2:0] f3;
    logic       alt;
    logic       is_ebreak;

    assign f3  = inst.rsi.funct3;
    assign alt = inst.rsi.funct7[5];
    // funct12 = 1 with everything else zero
    assign is_ebreak = (inst.uj.imm_hi == 20'h00100) && (inst.rsi.rd == '0);

    always_comb begin
        // defaults, nothing written, no memory access
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.wb_sel = wb_alu;
        ctrl.jump   = jump_none;
        imm_type    = imm_none;
        rs1_ren     = 1'b0;
        rs2_ren     = 1'b0;
        case (inst.rsi.opcode)
            op_lui: begin
                // rd = imm
                ctrl.alu_op    = alu_pass_b;
                ctrl.alu_src_b = 1'b1;
                ctrl.gpr_write = 1'b1;
                imm_type       = imm_u;
            end
            op_auipc: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = 1'b1;
                ctrl.gpr_write = 1'b1;
                imm_type       = imm_u;
            end
            op_jal: begin
                // target pc + imm, rd gets pc + 4
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = 1'b1;
                ctrl.gpr_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                ctrl.jump      = jump_jal;
                imm_type       = imm_j;
            end
            op_jalr: begin
                ctrl.alu_src_b = 1'b1;
                ctrl.gpr_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                ctrl.jump      = jump_jalr;
                imm_type       = imm_i;
                rs1_ren        = 1'b1;
            end
            op_branch: begin
                // compare via sub, condition in funct3
                ctrl.alu_op = alu_sub;
                ctrl.jump   = jump_branch;
                imm_type    = imm_b;
                rs1_ren     = 1'b1;
                rs2_ren     = 1'b1;
            end
            op_load: begin
                ctrl.alu_src_b = 1'b1;
                ctrl.gpr_write = 1'b1;
                ctrl.wb_sel    = wb_mem;
                ctrl.mem_read  = 1'b1;
                ctrl.mem_size  = f3;
                imm_type       = imm_i;
                rs1_ren        = 1'b1;
            end
            op_store: begin
                ctrl.alu_src_b = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = f3;
                imm_type       = imm_s;
                rs1_ren        = 1'b1;
                rs2_ren        = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = alu_fn(f3, alt, 1'b0);
                ctrl.alu_src_b = 1'b1;
                ctrl.gpr_write = 1'b1;
                imm_type       = imm_i;
                rs1_ren        = 1'b1;
            end
            op_op: begin
                ctrl.alu_op    = alu_fn(f3, alt, 1'b1);
                ctrl.gpr_write = 1'b1;
                rs1_ren        = 1'b1;
                rs2_ren        = 1'b1;
            end
            op_system: begin
                // only ebreak does anything, csr ops are not handled here
                ctrl.is_break = is_ebreak;
            end
            default: begin
                // unknown opcode, writes stay cleared
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      in_valid,
    output logic      in_ready,
    input  id_in_t    in,
    input  logic      stall,
    input  fwd_sel_e  fwd_a,
    input  fwd_sel_e  fwd_b,
    input  fwd_data_t fwd,
    input  gpr_wr_t   gpr_wr,
    output logic      dec_valid,
    input  logic      ex_ready,
    output id_ex_t    dec,
    output logic      rs1_ren,
    output logic      rs2_ren
);

    // operand mux, register file or a later stage
    function automatic logic [xlen-1:0] pick(input fwd_sel_e sel,
                                             input logic [xlen-1:0] rf,
                                             input fwd_data_t f);
        case (sel)
            fwd_exe: pick = f.exe;
            fwd_mem: pick = f.mem;
            fwd_wb:  pick = f.wb;
            default: pick = rf;
        endcase
    endfunction

    inst_u           inst;
    reg_idx_t        rs1_idx;
    reg_idx_t        rs2_idx;
    logic [xlen-1:0] rs1_rf;
    logic [xlen-1:0] rs2_rf;
    logic [xlen-1:0] imm;
    imm_type_e       imm_type;
    ctrl_t           ctrl;

    assign inst = inst_u'(in.inst);

    // rv32e, upper index bit ignored
    assign rs1_idx = inst.rsi.rs1[3:0];
    assign rs2_idx = inst.rsi.rs2[3:0];

    gpr_file u_gpr (
        .clk      (clk),
        .wr       (gpr_wr),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_rf),
        .rs2_data (rs2_rf)
    );

    imm_gen u_imm (
        .inst     (inst),
        .imm_type (imm_type),
        .imm      (imm)
    );

    decode_ctrl u_ctrl (
        .inst     (inst),
        .ctrl     (ctrl),
        .imm_type (imm_type),
        .rs1_ren  (rs1_ren),
        .rs2_ren  (rs2_ren)
    );

    // payload toward the stage register
    assign dec = '{
        pc:       in.pc,
        rs1_data: pick(fwd_a, rs1_rf, fwd),
        rs2_data: pick(fwd_b, rs2_rf, fwd),
        imm:      imm,
        rd:       inst.rsi.rd[3:0],
        ctrl:     ctrl
    };

    // stall blocks both sides of the handshake
    assign dec_valid = in_valid & ~stall;
    assign in_ready  = ex_ready & ~stall;

endmodule

//--- logic/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  id_ex_t in,
    output logic   out_valid,
    input  logic   out_ready,
    output id_ex_t out
);

    logic   full;
    id_ex_t data;

    // take a new entry when empty or the current one leaves now
    assign in_ready = ~full | out_ready;

    // valid flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    // payload, held while execute pushes back
    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            data <= in;
        end
    end

    assign out_valid = full;
    assign out       = data;

endmodule

//--- logic/id_top.sv
`timescale 1ns/1ps

module id_top
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  id_in_t    in,
    input  logic      stall,
    input  fwd_sel_e  fwd_a,
    input  fwd_sel_e  fwd_b,
    input  fwd_data_t fwd,
    input  gpr_wr_t   gpr_wr,
    output logic      out_valid,
    input  logic      out_ready,
    output id_ex_t    out,
    output logic      rs1_ren,
    output logic      rs2_ren
);

    // decode to stage register
    logic   dec_valid;
    logic   ex_ready;
    id_ex_t dec;

    decode_unit u_dec (
        .clk       (clk),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .fwd       (fwd),
        .gpr_wr    (gpr_wr),
        .dec_valid (dec_valid),
        .ex_ready  (ex_ready),
        .dec       (dec),
        .rs1_ren   (rs1_ren),
        .rs2_ren   (rs2_ren)
    );

    id_ex_reg u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .in_ready  (ex_ready),
        .in        (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

endmodule

//--- sim/tb_decode_model.svh
`ifndef tb_decode_model_svh
`define tb_decode_model_svh

// lfsr state, one step per bit taken
logic [31:0] lfsr_state = 32'h4c29_41d6;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r          = {r[30:0], fb};
    end
    return r;
endfunction

// formats that carry rs1
function automatic logic reads_rs1(input logic [31:0] i);
    return i[6:0] inside {op_jalr, op_branch, op_load, op_store, op_imm, op_op};
endfunction

// formats that carry rs2
function automatic logic reads_rs2(input logic [31:0] i);
    return i[6:0] inside {op_branch, op_store, op_op};
endfunction

// immediate straight from the isa bit positions
function automatic logic [31:0] ref_imm(input logic [31:0] i);
    case (i[6:0])
        op_jalr, op_load, op_imm: return {{20{i[31]}}, i[31:20]};
        op_store:                 return {{20{i[31]}}, i[31:25], i[11:7]};
        op_branch: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        op_lui, op_auipc:         return {i[31:12], 12'h000};
        op_jal:    return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        default:                  return 32'h0;
    endcase
endfunction

// alu function for op and op-imm, bit 30 picks sub or sra
function automatic alu_op_e ref_alu(input logic [31:0] i, input logic reg_form);
    case (i[14:12])
        3'd0:    return (reg_form && i[30]) ? alu_sub : alu_add;
        3'd1:    return alu_sll;
        3'd2:    return alu_slt;
        3'd3:    return alu_sltu;
        3'd4:    return alu_xor;
        3'd5:    return i[30] ? alu_sra : alu_srl;
        3'd6:    return alu_or;
        default: return alu_and;
    endcase
endfunction

// control word, one field at a time
function automatic ctrl_t ref_ctrl(input logic [31:0] i);
    ctrl_t      c;
    logic [6:0] opc;
    opc = i[6:0];
    c   = '0;
    c.alu_src_a = opc inside {op_auipc, op_jal};
    c.alu_src_b = opc inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_store, op_imm};
    c.gpr_write = opc inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_op};
    c.mem_read  = (opc == op_load);
    c.mem_write = (opc == op_store);
    if (opc == op_load || opc == op_store) begin
        c.mem_size = i[14:12];
    end
    c.wb_sel = wb_alu;
    if (opc == op_load) begin
        c.wb_sel = wb_mem;
    end else if (opc == op_jal || opc == op_jalr) begin
        c.wb_sel = wb_pc4;
    end
    case (opc)
        op_jal:    c.jump = jump_jal;
        op_jalr:   c.jump = jump_jalr;
        op_branch: c.jump = jump_branch;
        default:   c.jump = jump_none;
    endcase
    case (opc)
        op_lui:    c.alu_op = alu_pass_b;
        op_branch: c.alu_op = alu_sub;
        op_imm:    c.alu_op = ref_alu(i, 1'b0);
        op_op:     c.alu_op = ref_alu(i, 1'b1);
        default:   c.alu_op = alu_add;
    endcase
    // ebreak is one exact word
    c.is_break = (i == 32'h0010_0073);
    c.illegal  = !(opc inside {op_lui, op_auipc, op_jal, op_jalr, op_branch,
                               op_load, op_store, op_imm, op_op, op_system});
    return c;
endfunction

`endif

//--- sim/tb_id_top.sv
`timescale 1ns/1ps

module tb_id_top
    import rv_isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int clk_period = 4;
    localparam int num_inst   = 400;
    // 10 cycles per instruction plus reset and preload
    localparam int limit_cycles = num_inst * 10 + 100;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    id_in_t    in;
    logic      stall;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    fwd_data_t fwd;
    gpr_wr_t   gpr_wr;
    logic      out_valid;
    logic      out_ready;
    id_ex_t    out;
    logic      rs1_ren;
    logic      rs2_ren;

    // shadow of the register file, x0 included as written
    logic [31:0] shadow [16];
    id_ex_t      exp_q [$];
    id_ex_t      exp_head = '0;
    int          accepted = 0;
    int          received = 0;

    `include "tb_decode_model.svh"

    // last entry is a custom-0 opcode, not rv32i
    logic [6:0] opcode_table [11] = '{op_lui, op_auipc, op_jal, op_jalr, op_branch,
                                      op_load, op_store, op_imm, op_op, op_system,
                                      7'b0001011};

    id_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .fwd       (fwd),
        .gpr_wr    (gpr_wr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .rs1_ren   (rs1_ren),
        .rs2_ren   (rs2_ren)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic end_with_error(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            end_with_error($sformatf("FAIL at %0t ns: %s = 0x%08h, expected 0x%08h",
                                     $time, name, got, want));
        end
    endtask

    // first differing field of the payload
    task automatic compare_payload(input id_ex_t got, input id_ex_t want);
        check_field("out.pc", got.pc, want.pc);
        check_field("out.rs1_data", got.rs1_data, want.rs1_data);
        check_field("out.rs2_data", got.rs2_data, want.rs2_data);
        check_field("out.imm", got.imm, want.imm);
        check_field("out.rd", 32'(got.rd), 32'(want.rd));
        check_field("out.ctrl.alu_op", 32'(got.ctrl.alu_op), 32'(want.ctrl.alu_op));
        check_field("out.ctrl.alu_src_a", 32'(got.ctrl.alu_src_a), 32'(want.ctrl.alu_src_a));
        check_field("out.ctrl.alu_src_b", 32'(got.ctrl.alu_src_b), 32'(want.ctrl.alu_src_b));
        check_field("out.ctrl.gpr_write", 32'(got.ctrl.gpr_write), 32'(want.ctrl.gpr_write));
        check_field("out.ctrl.wb_sel", 32'(got.ctrl.wb_sel), 32'(want.ctrl.wb_sel));
        check_field("out.ctrl.jump", 32'(got.ctrl.jump), 32'(want.ctrl.jump));
        check_field("out.ctrl.mem_read", 32'(got.ctrl.mem_read), 32'(want.ctrl.mem_read));
        check_field("out.ctrl.mem_write", 32'(got.ctrl.mem_write), 32'(want.ctrl.mem_write));
        check_field("out.ctrl.mem_size", 32'(got.ctrl.mem_size), 32'(want.ctrl.mem_size));
        check_field("out.ctrl.is_break", 32'(got.ctrl.is_break), 32'(want.ctrl.is_break));
        check_field("out.ctrl.illegal", 32'(got.ctrl.illegal), 32'(want.ctrl.illegal));
        end_with_error("out differs from the expected payload in an unlisted bit");
    endtask

    // forwarded value wins over the register file
    function automatic logic [31:0] operand(input fwd_sel_e sel, input logic [3:0] idx);
        case (sel)
            fwd_exe: return fwd.exe;
            fwd_mem: return fwd.mem;
            fwd_wb:  return fwd.wb;
            default: return (idx == 4'd0) ? 32'h0 : shadow[idx];
        endcase
    endfunction

    // payload for the instruction on in, rv32e index bits only
    function automatic id_ex_t expected_payload();
        id_ex_t p;
        p.pc       = in.pc;
        p.rs1_data = operand(fwd_a, in.inst[18:15]);
        p.rs2_data = operand(fwd_b, in.inst[23:20]);
        p.imm      = ref_imm(in.inst);
        p.rd       = in.inst[10:7];
        p.ctrl     = ref_ctrl(in.inst);
        return p;
    endfunction

    function automatic logic [31:0] next_instruction();
        logic [31:0] r;
        logic [3:0]  k;
        logic [6:0]  opc;
        r   = rand_bits(4) % 11;
        k   = r[3:0];
        opc = opcode_table[k];
        r   = rand_bits(25);
        // half the system draws become ebreak
        if (opc == op_system && r[0]) begin
            return 32'h0010_0073;
        end else begin
            return {r[24:0], opc};
        end
    endfunction

    // stall, back-pressure, forwarding and writeback noise
    task automatic drive_side_inputs();
        logic [31:0] r;
        stall       = (rand_bits(3) == 0);
        out_ready   = (rand_bits(2) != 0);
        r           = rand_bits(4);
        fwd_a       = (r[3:2] == 2'd0) ? fwd_sel_e'(r[1:0]) : fwd_rf;
        r           = rand_bits(4);
        fwd_b       = (r[3:2] == 2'd0) ? fwd_sel_e'(r[1:0]) : fwd_rf;
        fwd.exe     = rand_bits(32);
        fwd.mem     = rand_bits(32);
        fwd.wb      = rand_bits(32);
        r           = rand_bits(5);
        gpr_wr.en   = r[4];
        gpr_wr.addr = r[3:0];
        gpr_wr.data = rand_bits(32);
    endtask

    // expected queue and shadow, both sampled before the edge updates
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                end_with_error("an output appeared with no instruction outstanding");
            end else begin
                void'(exp_q.pop_front());
                received++;
            end
        end
        if (rst_n && in_valid && in_ready) begin
            exp_q.push_back(expected_payload());
            accepted++;
        end
        // write lands after this edge's reads
        if (gpr_wr.en) begin
            shadow[gpr_wr.addr] = gpr_wr.data;
        end
        if (exp_q.size() != 0) begin
            exp_head = exp_q[0];
        end
    end

    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else end_with_error("out_valid was high right after reset");

    output_one_cycle_later: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |=> out_valid)
        else end_with_error("accepted instruction did not show up on the next cycle");

    payload_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out == exp_head)
        else compare_payload($sampled(out), $sampled(exp_head));

    hold_under_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else end_with_error("out or out_valid changed while out_ready was low");

    stall_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !in_ready)
        else end_with_error("in_ready was high during a stall");

    rs1_ren_matches: assert property (@(posedge clk) disable iff (!rst_n)
        rs1_ren == reads_rs1(in.inst))
        else check_field("rs1_ren", 32'($sampled(rs1_ren)), 32'(reads_rs1($sampled(in.inst))));

    rs2_ren_matches: assert property (@(posedge clk) disable iff (!rst_n)
        rs2_ren == reads_rs2(in.inst))
        else check_field("rs2_ren", 32'($sampled(rs2_ren)), 32'(reads_rs2($sampled(in.inst))));

    // watchdog
    initial begin
        #(clk_period * limit_cycles);
        end_with_error("timeout, the run did not drain in time");
    end

    initial begin
        logic [31:0] pc;
        logic        taken;
        rst_n     = 1'b0;
        // offered during reset, must never reach out
        in_valid  = 1'b1;
        in        = '0;
        stall     = 1'b0;
        fwd_a     = fwd_rf;
        fwd_b     = fwd_rf;
        fwd       = '0;
        gpr_wr    = '0;
        out_ready = 1'b1;
        pc        = 32'h0000_1000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        in_valid = 1'b0;
        // fill every register, x0 gets a nonzero value too
        for (int k = 0; k < 16; k++) begin
            gpr_wr.en   = 1'b1;
            gpr_wr.addr = 4'(k);
            gpr_wr.data = rand_bits(32) | 32'h1;
            @(negedge clk);
        end
        gpr_wr.en = 1'b0;
        for (int n = 0; n < num_inst; n++) begin
            // occasional bubble between instructions
            if (rand_bits(2) == 0) begin
                in_valid = 1'b0;
                drive_side_inputs();
                @(negedge clk);
            end
            in.inst  = next_instruction();
            in.pc    = pc;
            in_valid = 1'b1;
            pc       = pc + 32'd4;
            taken    = 1'b0;
            // hold the instruction until it is taken
            while (!taken) begin
                drive_side_inputs();
                @(posedge clk);
                taken = in_valid && in_ready;
                @(negedge clk);
            end
        end
        // drain the stage register
        in_valid  = 1'b0;
        stall     = 1'b0;
        out_ready = 1'b1;
        gpr_wr.en = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (accepted == num_inst && received == accepted && !out_valid) begin
            $display("Done: no errors");
            $finish;
        end else begin
            end_with_error("accepted and produced instruction counts do not match");
        end
    end

endmodule

//--- files.f
+incdir+sim
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/gpr_file.sv
logic/imm_gen.sv
logic/decode_ctrl.sv
logic/decode_unit.sv
logic/id_ex_reg.sv
logic/id_top.sv
sim/tb_id_top.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= files.f
RTL_TOP    ?= id_top
TB_TOP     ?= tb_id_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
RUN_ARGS   ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
